/* Bender.yml */
package:
  name: sub_bus

sources:
  - sub_bus_pkg.sv
  - sub_bus_if.sv
  - cen_frac.sv
  - bus_arbiter.sv
  - dtack_gen.sv
  - mem_decoder.sv
  - sub_bus_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sub_bus.sv

/* bus_arbiter.sv */
// 68000 bus request/grant/acknowledge sequencer for the main CPU
// and the mux that puts the owning master on the sub bus
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        sub_br,      // main CPU wants the sub bus
    input  logic        cpu_bg_n,
    input  logic        cpu_as_n,
    input  logic        cpu_uds_n,
    input  logic        cpu_lds_n,
    input  logic        cpu_rnw,
    input  logic [19:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [19:1] main_addr,
    input  logic [1:0]  main_dsn,
    input  logic        main_rnw,
    input  logic [15:0] main_dout,
    output logic        cpu_br_n,
    output logic        cpu_bgack_n,
    sub_bus_if.master   bus
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1; // br_n low, waiting for grant
    localparam logic [1:0] ST_OWN  = 2'd2; // bgack_n low, main CPU on the bus

    logic [1:0] state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else if (cen) begin
            case (state)
                ST_IDLE: if (sub_br) state <= ST_REQ;
                ST_REQ: begin
                    if (!sub_br)
                        state <= ST_IDLE;        // request withdrawn
                    else if (!cpu_bg_n && cpu_as_n)
                        state <= ST_OWN;         // CPU finished its cycle
                end
                ST_OWN: if (!sub_br) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign cpu_br_n    = state != ST_REQ;
    assign cpu_bgack_n = state != ST_OWN;

    // owner mux
    assign bus.addr.flat = cpu_bgack_n ? cpu_addr : main_addr;
    assign bus.dsn       = cpu_bgack_n ? {cpu_uds_n, cpu_lds_n} : main_dsn;
    assign bus.rnw       = cpu_bgack_n ? cpu_rnw : main_rnw;
    assign bus.wdata     = cpu_bgack_n ? cpu_dout : main_dout;
    assign bus.as_n      = cpu_bgack_n ? cpu_as_n : &main_dsn; // main has no AS
    assign bus.granted   = ~cpu_bgack_n;

    // the sub-CPU stays off the bus while the main CPU holds it
    a_cpu_off_bus: assert property (
        @(posedge clk) disable iff (rst) !cpu_bgack_n |-> cpu_as_n
    );

endmodule

`default_nettype wire

/* cen_frac.sv */
// fractional clock-enable generator for the external 68000
// each accumulator wrap emits one pulse, alternating between cen and cenb
`timescale 1ns/1ns
`default_nettype none

module cen_frac #(
    parameter logic [6:0] CEN_NUM = 7'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  logic clk,
    input  logic rst,
    output logic cen,
    output logic cenb
);

    logic [7:0] acc;
    logic [8:0] sum;
    logic       wrap;
    logic [7:0] acc_next;
    logic       phase;    // low: next wrap goes to cen

    assign sum      = {1'b0, acc} + {2'b00, CEN_NUM};
    assign wrap     = sum >= {1'b0, CEN_DEN};
    assign acc_next = wrap ? 8'(sum - {1'b0, CEN_DEN}) : sum[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            phase <= 1'b0;
            cen   <= 1'b0;
            cenb  <= 1'b0;
        end else begin
            acc  <= acc_next;
            cen  <= wrap & ~phase;
            cenb <= wrap &  phase;
            if (wrap)
                phase <= ~phase; // split wraps between the two phases
        end
    end

    // one subtraction per clock must bring the sum back below CEN_DEN
    a_acc_range: assert property (
        @(posedge clk) disable iff (rst) acc < CEN_DEN
    );

endmodule

`default_nettype wire

/* dtack_gen.sv */
// DTACK and VPA generation for the sub-CPU
// DTACK waits for slow memories; interrupt acknowledge is autovectored
`timescale 1ns/1ns
`default_nettype none

module dtack_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       cpu_as_n,
    input  logic [2:0] cpu_fc,
    input  logic       bus_cs,    // ROM or RAM selected
    input  logic       busy,      // selected memory not ready
    output logic       cpu_dtack_n,
    output logic       cpu_vpa_n
);

    logic inta;
    logic as_n_q;
    logic as_settled;
    logic mem_ready;

    assign inta      = ~cpu_as_n && cpu_fc == 3'd7; // interrupt acknowledge
    assign cpu_vpa_n = ~inta;                       // autovector request

    // selects and read word lag AS by a clock
    assign as_settled = ~cpu_as_n & ~as_n_q;
    assign mem_ready  = ~(bus_cs & busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_n_q      <= 1'b1;
            cpu_dtack_n <= 1'b1;
        end else begin
            as_n_q <= cpu_as_n;
            if (cpu_as_n)
                cpu_dtack_n <= 1'b1;                // end of cycle
            else if (cen && as_settled && mem_ready && !inta)
                cpu_dtack_n <= 1'b0;
        end
    end

    // function code holds for the whole bus cycle
    a_fc_stable: assert property (
        @(posedge clk) disable iff (rst) !cpu_as_n && $past(!cpu_as_n) |-> $stable(cpu_fc)
    );

    // an autovectored cycle never gets DTACK
    a_no_dtack_inta: assert property (
        @(posedge clk) disable iff (rst) inta && $past(inta) |-> cpu_dtack_n
    );

endmodule

`default_nettype wire

/* mem_decoder.sv */
// memory map decoder of the sub bus
// registers the chip selects and the read word, and flags slow memories
`timescale 1ns/1ns
`default_nettype none

module mem_decoder (
    input  logic        clk,
    input  logic        rst,
    sub_bus_if.slave    bus,
    input  logic        rom_ok,
    input  logic [15:0] rom_data,
    input  logic        ram_ok,
    input  logic [15:0] ram_data,
    input  logic [15:0] road_dout,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        road_cs,
    output logic        sio_cs,
    output logic        busy,
    output logic        bus_ok,
    output logic [15:0] rdata
);

    logic [2:0] region;
    logic       strobe;      // any data strobe low
    logic       active;
    logic       granted_q;

    assign region = bus.addr.map.region;
    assign strobe = ~&bus.dsn;
    assign active = strobe | bus.granted | (~bus.as_n & bus.rnw);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            road_cs   <= 1'b0;
            sio_cs    <= 1'b0;
            granted_q <= 1'b0;
        end else begin
            granted_q <= bus.granted;
            if (active) begin
                rom_cs  <= region <= sub_bus_pkg::REG_ROM_LAST;
                ram_cs  <= region == sub_bus_pkg::REG_RAM && strobe;  // writes need a strobe
                road_cs <= region == sub_bus_pkg::REG_ROAD && !bus.addr.map.road_sel;
                sio_cs  <= region == sub_bus_pkg::REG_ROAD &&  bus.addr.map.road_sel;
            end else begin
                rom_cs  <= 1'b0;
                ram_cs  <= 1'b0;
                road_cs <= 1'b0;
                sio_cs  <= 1'b0;
            end
        end
    end

    // read word, one clock behind the selects
    always_ff @(posedge clk) begin
        rdata <= rom_cs  ? rom_data  :
                 ram_cs  ? ram_data  :
                 road_cs ? road_dout :
                 sub_bus_pkg::OPEN_BUS;
    end

    assign busy   = (rom_cs & ~rom_ok) | (ram_cs & ~ram_ok);
    assign bus_ok = granted_q & ~busy; // main CPU may proceed

    // write data holds while RAM is selected for a write
    a_wdata_stable: assert property (
        @(posedge clk) disable iff (rst)
            ram_cs && $past(ram_cs) && !bus.rnw |-> $stable(bus.wdata)
    );

endmodule

`default_nettype wire

/* sub_bus.f */
+incdir+.
sub_bus_pkg.sv
sub_bus_if.sv
cen_frac.sv
bus_arbiter.sv
dtack_gen.sv
mem_decoder.sv
sub_bus_top.sv
tb_sub_bus.sv

/* sub_bus_if.sv */
// arbitrated sub bus, driven by the arbiter and read by the memory decoder
// carries whichever master currently owns the bus
`timescale 1ns/1ns
`default_nettype none

interface sub_bus_if;

    sub_bus_pkg::bus_addr_t addr;     // word address of the owning master
    logic [1:0]             dsn;      // {uds_n, lds_n}
    logic                   rnw;
    logic [15:0]            wdata;
    logic                   as_n;
    logic                   granted;  // main CPU owns the bus

    modport master (
        output addr, dsn, rnw, wdata, as_n, granted
    );

    modport slave (
        input  addr, dsn, rnw, wdata, as_n, granted
    );

endinterface

`default_nettype wire

/* sub_bus_pkg.sv */
// shared address view, memory-map region codes and bus constants
// for the sub-CPU bus subsystem; RTL files use these by scoped name
`default_nettype none

package sub_bus_pkg;

    // word address 19..1, read flat by the arbiter and split by the decoder
    typedef union packed {
        logic [19:1] flat;
        struct packed {
            logic [2:0]  region;   // address 19..17
            logic        road_sel; // address 16, road RAM or serial I/O
            logic [14:0] offset;   // word offset inside the region
        } map;
    } bus_addr_t;

    // memory map, one region per 128 kB
    localparam logic [2:0] REG_ROM_LAST = 3'd2; // regions 0..2 hold ROM
    localparam logic [2:0] REG_RAM      = 3'd3;
    localparam logic [2:0] REG_ROAD     = 3'd4; // anything above is unmapped

    // returned when a read selects no memory
    localparam logic [15:0] OPEN_BUS = 16'hffff;

endpackage

`default_nettype wire

/* sub_bus_top.sv */
// top level of the sub-CPU bus subsystem
// the sub-CPU, main CPU and memories connect here through plain ports
`timescale 1ns/1ns
`default_nettype none

module sub_bus_top #(
    parameter logic [6:0] CEN_NUM = 7'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  logic        clk,
    input  logic        rst,
    // sub-CPU
    input  logic [23:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic        cpu_as_n,
    input  logic        cpu_uds_n,
    input  logic        cpu_lds_n,
    input  logic        cpu_rnw,
    input  logic [2:0]  cpu_fc,
    input  logic        cpu_bg_n,
    output logic [15:0] cpu_din,
    output logic        cpu_dtack_n,
    output logic        cpu_vpa_n,
    output logic        cpu_br_n,
    output logic        cpu_bgack_n,
    output logic        cpu_cen,
    output logic        cpu_cenb,
    // main CPU
    input  logic [19:1] main_addr,
    input  logic [1:0]  main_dsn,
    input  logic        main_rnw,
    input  logic [15:0] main_dout,
    input  logic        sub_br,
    output logic [15:0] sub_din,
    output logic        sub_ok,
    // memories
    output logic [18:1] sub_addr,
    output logic [15:0] mem_dout,
    output logic        rnw,
    output logic [1:0]  dsn,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        road_cs,
    output logic        sio_cs,
    input  logic        rom_ok,
    input  logic [15:0] rom_data,
    input  logic        ram_ok,
    input  logic [15:0] ram_data,
    input  logic [15:0] road_dout
);

    sub_bus_if u_bus ();

    logic        busy;
    logic        bus_cs;
    logic [15:0] rdata;

    cen_frac #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_cen (
        .clk  (clk),
        .rst  (rst),
        .cen  (cpu_cen),
        .cenb (cpu_cenb)
    );

    bus_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .cen         (cpu_cen),
        .sub_br      (sub_br),
        .cpu_bg_n    (cpu_bg_n),
        .cpu_as_n    (cpu_as_n),
        .cpu_uds_n   (cpu_uds_n),
        .cpu_lds_n   (cpu_lds_n),
        .cpu_rnw     (cpu_rnw),
        .cpu_addr    (cpu_addr[19:1]), // upper lines mirror the 1 MB map
        .cpu_dout    (cpu_dout),
        .main_addr   (main_addr),
        .main_dsn    (main_dsn),
        .main_rnw    (main_rnw),
        .main_dout   (main_dout),
        .cpu_br_n    (cpu_br_n),
        .cpu_bgack_n (cpu_bgack_n),
        .bus         (u_bus)
    );

    mem_decoder u_dec (
        .clk       (clk),
        .rst       (rst),
        .bus       (u_bus),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .ram_ok    (ram_ok),
        .ram_data  (ram_data),
        .road_dout (road_dout),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .road_cs   (road_cs),
        .sio_cs    (sio_cs),
        .busy      (busy),
        .bus_ok    (sub_ok),
        .rdata     (rdata)
    );

    assign bus_cs = rom_cs | ram_cs; // only these can stall

    dtack_gen u_dtack (
        .clk         (clk),
        .rst         (rst),
        .cen         (cpu_cen),
        .cpu_as_n    (cpu_as_n),
        .cpu_fc      (cpu_fc),
        .bus_cs      (bus_cs),
        .busy        (busy),
        .cpu_dtack_n (cpu_dtack_n),
        .cpu_vpa_n   (cpu_vpa_n)
    );

    assign sub_addr = u_bus.addr.flat[18:1];
    assign dsn      = u_bus.dsn;
    assign rnw      = u_bus.rnw;
    assign mem_dout = u_bus.wdata;
    assign cpu_din  = rdata;
    assign sub_din  = rdata; // same word serves both masters

endmodule

`default_nettype wire

/* tb_sub_bus_tasks.svh */
// sub-CPU bus cycles, compare tasks and directed tests of the testbench
// included inside tb_sub_bus, uses its signals directly

localparam int SIG_DTACK = 0;
localparam int SIG_BR    = 1;
localparam int SIG_BGACK = 2;
localparam int SIG_OK    = 3;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
        r = {r[14:0], lfsr_step()};
    return r;
endfunction

// word offset inside a region
function automatic logic [14:0] rand_offset();
    logic [15:0] r;
    r = rand_bits(15);
    return r[14:0];
endfunction

// word address from region, road/serial bit and offset
function automatic logic [23:1] map_addr(input logic [2:0] region, input logic sel,
                                         input logic [14:0] offset);
    return {4'd0, region, sel, offset};
endfunction

function automatic logic [3:0] cs_pattern();
    return {rom_cs, ram_cs, road_cs, sio_cs};
endfunction

function automatic logic probe(input int sel);
    case (sel)
        SIG_DTACK: return cpu_dtack_n;
        SIG_BR:    return cpu_br_n;
        SIG_BGACK: return cpu_bgack_n;
        default:   return sub_ok;
    endcase
endfunction

task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_addr(input string what, input logic [18:1] got, input logic [18:1] exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t %s: address %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_cs(input string what, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t %s: selects %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t %s: got %b, expected %b", $time, what, got, exp);
    end
endtask

// outputs are sampled on the falling edge
task automatic wait_for(input int sel, input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (probe(sel) !== level) begin
        errors++;
        $display("timed out after %0d cycles, the DUT never gave %s", n, what);
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before)
        $display("test %-14s passed", name);
    else
        $display("test %-14s failed with %0d errors", name, errors - errs_before);
endtask

task automatic start_cycle(input logic [23:1] addr, input logic rd, input logic [1:0] strb,
                           input logic [15:0] wd, input logic [2:0] fc);
    @(posedge clk);
    cpu_addr               <= addr;
    cpu_rnw                <= rd;
    cpu_dout               <= wd;
    cpu_fc                 <= fc;
    cpu_as_n               <= 1'b0;
    {cpu_uds_n, cpu_lds_n} <= strb;
endtask

task automatic end_cycle();
    @(posedge clk);
    cpu_as_n  <= 1'b1;
    cpu_uds_n <= 1'b1;
    cpu_lds_n <= 1'b1;
    cpu_rnw   <= 1'b1;
    wait_for(SIG_DTACK, 1'b1, "DTACK release");
endtask

task automatic cpu_read(input logic [23:1] addr, output logic [15:0] data,
                        output logic [3:0] cs);
    start_cycle(addr, 1'b1, 2'b00, 16'h0000, 3'd5);
    wait_for(SIG_DTACK, 1'b0, "DTACK on a read");
    data = cpu_din;
    cs   = cs_pattern();
    end_cycle();
endtask

task automatic reset_values();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_bit("dtack_n after reset", cpu_dtack_n, 1'b1);
    check_bit("vpa_n after reset", cpu_vpa_n, 1'b1);
    check_bit("br_n after reset", cpu_br_n, 1'b1);
    check_bit("bgack_n after reset", cpu_bgack_n, 1'b1);
    check_bit("cen after reset", cpu_cen, 1'b0);
    check_bit("cenb after reset", cpu_cenb, 1'b0);
    check_cs("selects after reset", cs_pattern(), 4'b0000);
    report_test("reset_state", e0);
endtask

// over two denominators the accumulator wraps twice CEN_NUM times
task automatic enable_rate();
    int         e0;
    int         n_cen;
    int         n_cenb;
    logic [1:0] last;                       // 10 after cen, 01 after cenb
    logic       order_ok;
    e0       = errors;
    n_cen    = 0;
    n_cenb   = 0;
    last     = 2'b00;
    order_ok = 1'b1;
    repeat (2 * CEN_DEN) begin
        @(negedge clk);
        if (cpu_cen && cpu_cenb) begin
            order_ok = 1'b0;
        end else if (cpu_cen) begin
            if (last == 2'b10)
                order_ok = 1'b0;
            last = 2'b10;
            n_cen++;
        end else if (cpu_cenb) begin
            if (last == 2'b01)
                order_ok = 1'b0;
            last = 2'b01;
            n_cenb++;
        end
    end
    check_word("cen pulses", 16'(n_cen), 16'(CEN_NUM));
    check_word("cenb pulses", 16'(n_cenb), 16'(CEN_NUM));
    check_bit("cen and cenb alternate", order_ok, 1'b1);
    report_test("enable_rate", e0);
endtask

task automatic rom_read();
    int          e0;
    logic [15:0] w;
    logic [15:0] data;
    logic [3:0]  cs;
    e0 = errors;
    w  = rand_bits(16);
    @(posedge clk);
    rom_data <= w;
    cpu_read(map_addr(3'd1, 1'b0, rand_offset()), data, cs);
    check_cs("rom read selects", cs, 4'b1000);
    check_word("rom read data", data, w);
    report_test("rom_read", e0);
endtask

task automatic ram_write();
    int          e0;
    logic [15:0] w;
    e0 = errors;
    w  = rand_bits(16);
    start_cycle(map_addr(3'd3, 1'b0, rand_offset()), 1'b0, 2'b01, w, 3'd5); // upper byte
    wait_for(SIG_DTACK, 1'b0, "DTACK on a RAM write");
    check_cs("ram write selects", cs_pattern(), 4'b0100);
    check_word("ram write data", mem_dout, w);
    check_bit("ram write uds_n", dsn[1], 1'b0);
    check_bit("ram write lds_n", dsn[0], 1'b1);
    check_bit("ram write rnw", rnw, 1'b0);
    end_cycle();
    report_test("ram_write", e0);
endtask

task automatic region4_decode();
    int          e0;
    logic [15:0] w;
    logic [15:0] data;
    logic [3:0]  cs;
    e0 = errors;
    w  = rand_bits(16);
    @(posedge clk);
    road_dout <= w;
    cpu_read(map_addr(3'd4, 1'b0, rand_offset()), data, cs);
    check_cs("road selects", cs, 4'b0010);
    check_word("road data", data, w);
    cpu_read(map_addr(3'd4, 1'b1, rand_offset()), data, cs);
    check_cs("serial I/O selects", cs, 4'b0001);
    check_word("serial I/O data", data, OPEN_BUS_WORD);
    for (int r = 5; r < 8; r++) begin
        cpu_read(map_addr(3'(r), 1'b0, rand_offset()), data, cs);
        check_cs("unmapped selects", cs, 4'b0000);
        check_word("unmapped data", data, OPEN_BUS_WORD);
    end
    report_test("region4_open", e0);
endtask

task automatic rom_stall();
    int          e0;
    logic [15:0] w;
    logic        held;
    e0   = errors;
    w    = rand_bits(16);
    held = 1'b1;
    @(posedge clk);
    rom_ok   <= 1'b0;
    rom_data <= w;
    start_cycle(map_addr(3'd0, 1'b0, rand_offset()), 1'b1, 2'b00, 16'h0000, 3'd5);
    repeat (24) begin                       // several cen periods of stall
        @(negedge clk);
        if (cpu_dtack_n !== 1'b1)
            held = 1'b0;
    end
    check_bit("dtack_n held while rom_ok low", held, 1'b1);
    @(posedge clk);
    rom_ok <= 1'b1;
    wait_for(SIG_DTACK, 1'b0, "DTACK after rom_ok rose");
    check_word("stalled rom data", cpu_din, w);
    end_cycle();
    report_test("back_pressure", e0);
endtask

task automatic interrupt_ack();
    int   e0;
    logic held;
    e0   = errors;
    held = 1'b1;
    start_cycle(23'h7fffff, 1'b1, 2'b00, 16'h0000, 3'd7);
    @(negedge clk);
    check_bit("vpa_n on interrupt ack", cpu_vpa_n, 1'b0);
    repeat (20) begin
        @(negedge clk);
        if (cpu_dtack_n !== 1'b1)
            held = 1'b0;
    end
    check_bit("dtack_n stays high on interrupt ack", held, 1'b1);
    end_cycle();
    check_bit("vpa_n after interrupt ack", cpu_vpa_n, 1'b1);
    report_test("int_ack", e0);
endtask

task automatic bus_steal();
    int          e0;
    logic [15:0] w;
    logic [23:1] a;
    e0 = errors;
    w  = rand_bits(16);
    a  = map_addr(3'd0, 1'b0, rand_offset());
    @(posedge clk);
    rom_data  <= w;
    main_addr <= a[19:1];
    main_dsn  <= 2'b00;
    main_rnw  <= 1'b1;
    sub_br    <= 1'b1;
    wait_for(SIG_BR, 1'b0, "bus request");
    @(posedge clk);
    cpu_bg_n <= 1'b0;                       // sub-CPU grants, no cycle running
    wait_for(SIG_BGACK, 1'b0, "bus grant acknowledge");
    check_bit("br_n released after acknowledge", cpu_br_n, 1'b1);
    wait_for(SIG_OK, 1'b1, "sub_ok to the main CPU");
    check_addr("sub_addr follows main", sub_addr, a[18:1]);
    @(negedge clk);                          // read word lags the select
    check_word("main read data", sub_din, w);
    a = map_addr(3'd2, 1'b0, rand_offset());
    @(posedge clk);
    main_addr <= a[19:1];
    @(negedge clk);
    check_addr("sub_addr follows new main", sub_addr, a[18:1]);
    @(posedge clk);
    sub_br <= 1'b0;
    wait_for(SIG_BGACK, 1'b1, "bus release");
    @(posedge clk);
    cpu_bg_n <= 1'b1;
    main_dsn <= 2'b11;
    report_test("bus_steal", e0);
endtask

/* tb_sub_bus.sv */
// testbench for the sub-CPU bus subsystem
// plays the sub-CPU, the main CPU and the memories around sub_bus_top
`timescale 1ns/1ns
`default_nettype none

module tb_sub_bus;

    localparam int NUM_TRANS  = 10;          // bus transactions over all tests
    localparam int WAIT_LIMIT = 400;         // cycles before a wait gives up
    localparam int CEN_NUM    = 29;
    localparam int CEN_DEN    = 146;
    localparam logic [15:0] OPEN_BUS_WORD = 16'hffff;

    logic        clk;
    logic        rst;
    logic [23:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic        cpu_as_n;
    logic        cpu_uds_n;
    logic        cpu_lds_n;
    logic        cpu_rnw;
    logic [2:0]  cpu_fc;
    logic        cpu_bg_n;
    logic [15:0] cpu_din;
    logic        cpu_dtack_n;
    logic        cpu_vpa_n;
    logic        cpu_br_n;
    logic        cpu_bgack_n;
    logic        cpu_cen;
    logic        cpu_cenb;
    logic [19:1] main_addr;
    logic [1:0]  main_dsn;
    logic        main_rnw;
    logic [15:0] main_dout;
    logic        sub_br;
    logic [15:0] sub_din;
    logic        sub_ok;
    logic [18:1] sub_addr;
    logic [15:0] mem_dout;
    logic        rnw;
    logic [1:0]  dsn;
    logic        rom_cs;
    logic        ram_cs;
    logic        road_cs;
    logic        sio_cs;
    logic        rom_ok;
    logic [15:0] rom_data;
    logic        ram_ok;
    logic [15:0] ram_data;
    logic [15:0] road_dout;

    int          errors;
    int          tests;
    logic [15:0] lfsr;                       // random source for data and offsets

    sub_bus_top #(
        .CEN_NUM (7'(CEN_NUM)),
        .CEN_DEN (8'(CEN_DEN))
    ) UUT (.*);

    `include "tb_sub_bus_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit scales with the number of transactions
    initial begin
        #(NUM_TRANS * 4000);
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        errors    = 0;
        tests     = 0;
        lfsr      = 16'd9;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_as_n  = 1'b1;
        cpu_uds_n = 1'b1;
        cpu_lds_n = 1'b1;
        cpu_rnw   = 1'b1;
        cpu_fc    = 3'd5;
        cpu_bg_n  = 1'b1;
        main_addr = '0;
        main_dsn  = 2'b11;
        main_rnw  = 1'b1;
        main_dout = '0;
        sub_br    = 1'b0;
        rom_ok    = 1'b1;
        rom_data  = '0;
        ram_ok    = 1'b1;
        ram_data  = '0;
        road_dout = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        enable_rate();
        rom_read();
        ram_write();
        region4_decode();
        rom_stall();
        interrupt_ack();
        bus_steal();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
